//--- vlog.f
hdl/lau_pkg.sv
hdl/prefix_and.sv
hdl/neg_c.sv
hdl/negate_stage.sv
hdl/sat_stage.sv
hdl/neg_unit.sv
dv/tb_neg_unit.sv

//--- Bender.yml
package:
  name: neg_unit

sources:
  # Package first, then leaf modules up to the top level
  - hdl/lau_pkg.sv
  - hdl/prefix_and.sv
  - hdl/neg_c.sv
  - hdl/negate_stage.sv
  - hdl/sat_stage.sv
  - hdl/neg_unit.sv

  # Testbench, only in simulation builds
  - target: test
    files:
      - dv/tb_neg_unit.sv

//--- dv/tb_neg_unit.sv
// Sign conditioning unit testbench
module tb_neg_unit #(
	parameter lau_pkg::speed_e speed = lau_pkg::FAST // Rebuild with SLOW or MEDIUM too
);
	import lau_pkg::*;

	localparam int n_basic  = 4 * 2 * 7; // Ops x sat x values
	localparam int n_min    = 8;
	localparam int n_stream = 200;
	localparam int n_bp     = 120;
	localparam int n_rst    = 8 + 20;    // Before and after the reset
	localparam int stall_budget = 80;    // Max low cycles of rsp_ready
	localparam int n_total  = n_basic + n_min + n_stream + n_bp + n_rst;

	logic     clk = 1'b0;
	logic     reset;
	logic     req_valid;
	logic     req_ready;
	neg_req_t req;
	logic     rsp_valid;
	logic     rsp_ready;
	neg_rsp_t rsp;

	neg_rsp_t exp_q [$];      // Expected responses oldest first
	int       acc_edges [$];  // Acceptance edge per request
	int       rsp_edges [$];  // Transfer edge per response
	int       cyc = 0;        // Rising edges so far
	int       cyc_limit = 1;
	int       n_checks = 0;
	int       n_errors = 0;
	int       n_rsp = 0;
	int       stall_left = 0;
	logic     stall_on = 1'b0;  // Random rsp_ready enabled
	logic     timing_on = 1'b0; // Record edges for latency check
	logic     was_stalled = 1'b0;
	logic     saw_full = 1'b0;  // req_ready seen low
	neg_rsp_t held;             // rsp at the last stalled sample

	neg_unit #(
		.speed(speed)
	) u_neg_unit (
		.clk      (clk),
		.reset    (reset),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req      (req),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp      (rsp)
	);

	always #20 clk = ~clk;

	// Cycle count and run limit
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc >= cyc_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cyc);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Random back-pressure bounded by stall_left
	always @(posedge clk) begin
		#2;
		if (stall_on && stall_left > 0 && ($urandom % 2 == 0)) begin
			rsp_ready = 1'b0;
			stall_left--;
		end else begin
			rsp_ready = 1'b1;
		end
	end

	// Expected response from the op rules in plain integer arithmetic
	function automatic neg_rsp_t expected_rsp(input neg_req_t r);
		int       v;
		int       z;
		neg_rsp_t e;
		v = $signed(r.operand);
		case (r.op)
			OP_NEG:  z = -v;
			OP_ABS:  z = (v < 0) ? -v : v;
			OP_NABS: z = (v > 0) ? -v : v;
			default: z = v;
		endcase
		e.ovf = (z >= (1 << (data_w - 1))); // Only -min lands here
		if (e.ovf && r.sat) begin
			e.result = {1'b0, {(data_w - 1){1'b1}}};
		end else begin
			e.result = z[data_w-1:0]; // Wraps back to min
		end
		return e;
	endfunction

	function automatic neg_req_t make_req(input op_e op, input logic sat, input word_t a);
		neg_req_t r;
		r.op      = op;
		r.sat     = sat;
		r.operand = a;
		return r;
	endfunction

	function automatic neg_req_t rand_req();
		word_t a;
		a = word_t'($urandom);
		if ($urandom % 8 == 0) begin
			a = {1'b1, {(data_w - 1){1'b0}}}; // Hit the overflow case often
		end
		return make_req(op_e'($urandom % 4), logic'($urandom % 2), a);
	endfunction

	task automatic check_word(input word_t got, input word_t exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_rsp(input neg_rsp_t got, input neg_rsp_t exp, input string what);
		check_word(got.result, exp.result, {what, " result"});
		check_bit(got.ovf, exp.ovf, {what, " ovf"});
	endtask

	// Response monitor sampled at the falling edge
	always @(negedge clk) begin
		if (reset) begin
			was_stalled = 1'b0;
		end else begin
			if (was_stalled) begin
				check_bit(rsp_valid, 1'b1, "rsp_valid while stalled");
				check_rsp(rsp, held, "stalled rsp");
			end
			if (!req_ready) begin
				saw_full = 1'b1;
				if (!(rsp_valid && !rsp_ready)) begin
					n_errors++;
					$display("FAILED %0t: req_ready low while output not stalled", $time);
				end
			end
			if (rsp_valid && rsp_ready) begin // Transfer on the next edge
				if (exp_q.size() == 0) begin
					n_errors++;
					$display("Error at %0t: response with no request outstanding", $time);
				end else begin
					check_rsp(rsp, exp_q.pop_front(), $sformatf("rsp %0d", n_rsp));
				end
				if (timing_on) rsp_edges.push_back(cyc + 1);
				n_rsp++;
			end
			was_stalled = rsp_valid && !rsp_ready;
			held        = rsp;
		end
	end

	// Starts just after a rising edge and returns just after the accepting one
	task automatic send_req(input neg_req_t r);
		req_valid = 1'b1;
		req       = r;
		@(negedge clk);
		while (!req_ready) @(negedge clk);
		exp_q.push_back(expected_rsp(r));
		if (timing_on) acc_edges.push_back(cyc + 1);
		@(posedge clk);
		#2;
		req_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) @(posedge clk);
		@(posedge clk);
		#2;
	endtask

	task automatic report_test(input string name);
		$display("[%0t] %s finished, %0d checks, %0d errors so far", $time, name,
			n_checks, n_errors);
	endtask

	task automatic basic_ops();
		word_t vals [7];
		vals = '{16'h0000, 16'h0001, 16'hffff, 16'h7fff, 16'h1234, 16'hedcb, 16'h0080};
		for (int o = 0; o < 4; o++) begin
			for (int s = 0; s < 2; s++) begin
				foreach (vals[i]) send_req(make_req(op_e'(o), logic'(s), vals[i]));
			end
		end
		wait_drain();
		report_test("basic_ops");
	endtask

	task automatic most_negative();
		for (int o = 0; o < 4; o++) begin
			send_req(make_req(op_e'(o), 1'b0, 16'h8000)); // Wrapped result
			send_req(make_req(op_e'(o), 1'b1, 16'h8000)); // Clamped when ovf
		end
		wait_drain();
		report_test("most_negative");
	endtask

	task automatic long_stream();
		acc_edges.delete();
		rsp_edges.delete();
		timing_on = 1'b1;
		for (int i = 0; i < n_stream; i++) send_req(rand_req());
		wait_drain();
		timing_on = 1'b0;
		if (rsp_edges.size() != acc_edges.size()) begin
			n_errors++;
			$display("Error: %0d responses for %0d requests in the stream",
				rsp_edges.size(), acc_edges.size());
		end else begin
			foreach (rsp_edges[i]) begin
				if (rsp_edges[i] != acc_edges[i] + 2) begin
					n_errors++;
					$display("Error: response %0d came %0d cycles after acceptance, not 2",
						i, rsp_edges[i] - acc_edges[i]);
				end
				if (i > 0 && rsp_edges[i] != rsp_edges[i-1] + 1) begin
					n_errors++;
					$display("Error: gap in the response stream before response %0d", i);
				end
			end
		end
		report_test("long_stream");
	endtask

	task automatic random_backpressure();
		saw_full   = 1'b0;
		stall_left = stall_budget;
		stall_on   = 1'b1;
		for (int i = 0; i < n_bp; i++) send_req(rand_req());
		wait_drain();
		stall_on = 1'b0;
		if (!saw_full) begin
			n_errors++;
			$display("Error: req_ready never fell under back-pressure");
		end
		report_test("random_backpressure");
	endtask

	task automatic reset_mid_stream();
		for (int i = 0; i < 8; i++) send_req(rand_req());
		reset = 1'b1; // Last two words still in flight
		exp_q.delete();
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		check_bit(rsp_valid, 1'b0, "rsp_valid after reset");
		@(posedge clk);
		#2;
		for (int i = 0; i < 20; i++) send_req(rand_req());
		wait_drain();
		report_test("reset_mid_stream");
	endtask

	initial begin
		void'($urandom(32'h9bb4_6fbc));
		cyc_limit = n_total + stall_budget + 40 * (log2floor(n_total) + 1);
		reset     = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		rsp_ready = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;

		basic_ops();
		most_negative();
		long_stream();
		random_backpressure();
		reset_mid_stream();

		$display("Summary: %0d checks, %0d errors, %0d responses", n_checks, n_errors, n_rsp);
		if (n_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- hdl/neg_unit.sv
// Sign conditioning unit top level
module neg_unit #(
	parameter lau_pkg::speed_e speed = lau_pkg::FAST // Prefix structure
) (
	input  logic              clk,
	input  logic              reset,     // Sync, active high

	// Request side
	input  logic              req_valid,
	output logic              req_ready,
	input  lau_pkg::neg_req_t req,

	// Response side
	output logic              rsp_valid,
	input  logic              rsp_ready,
	output lau_pkg::neg_rsp_t rsp
);
	import lau_pkg::*;

	logic     mid_valid; // Negate stage holds a word
	logic     mid_ready; // Saturate stage can take it
	neg_mid_t mid;       // Result, ovf and sat between stages

	// Stage 1, op decode and conditional complement
	negate_stage #(
		.speed(speed)
	) u_negate_stage (
		.clk      (clk),
		.reset    (reset),
		.in_valid (req_valid),
		.in_ready (req_ready),
		.in_req   (req),
		.out_valid(mid_valid),
		.out_ready(mid_ready),
		.out_mid  (mid)
	);

	// Stage 2, clamp on overflow
	sat_stage u_sat_stage (
		.clk      (clk),
		.reset    (reset),
		.in_valid (mid_valid),
		.in_ready (mid_ready),
		.in_mid   (mid),
		.out_valid(rsp_valid),
		.out_ready(rsp_ready),
		.out_rsp  (rsp)
	);

endmodule

//--- hdl/sat_stage.sv
// Saturate pipeline stage
module sat_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,  // Word from negate stage
	output logic              in_ready,  // Backpressure to negate stage
	input  lau_pkg::neg_mid_t in_mid,
	output logic              out_valid, // Response present
	input  logic              out_ready, // Consumer takes it
	output lau_pkg::neg_rsp_t out_rsp
);
	import lau_pkg::*;

	// 0x7fff for 16 bits
	localparam word_t word_max = {1'b0, {(data_w - 1){1'b1}}};

	logic     clamp;    // Overflowed and saturation asked for
	neg_rsp_t rsp_next; // Response to load

	assign clamp = in_mid.ovf & in_mid.sat;

	// Replace the wrapped result, flag reported either way
	always_comb begin
		rsp_next.result = clamp ? word_max : in_mid.result;
		rsp_next.ovf    = in_mid.ovf;
	end

	// Same one-deep register scheme as the negate stage
	assign in_ready = ~out_valid | out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// Held stable while out_ready is low
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_rsp <= rsp_next;
		end
	end

endmodule

//--- hdl/negate_stage.sv
// Negate pipeline stage
module negate_stage #(
	parameter lau_pkg::speed_e speed = lau_pkg::FAST // Prefix structure of neg_c
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,  // Request present
	output logic              in_ready,  // Stage can take it
	input  lau_pkg::neg_req_t in_req,
	output logic              out_valid, // Register holds a word
	input  logic              out_ready, // Saturate stage takes it
	output lau_pkg::neg_mid_t out_mid
);
	import lau_pkg::*;

	// 0x8000 for 16 bits, has no positive counterpart
	localparam word_t word_min = {1'b1, {(data_w - 1){1'b0}}};

	logic     sign;     // Operand sign bit
	logic     neg_en;   // Complementer enable
	logic     is_min;   // Operand is the most negative value
	word_t    negated;  // Complementer output
	neg_mid_t mid_next; // Record to load into the register

	assign sign   = in_req.operand[data_w-1];
	assign is_min = (in_req.operand == word_min);

	// Op decode
	always_comb begin
		case (in_req.op)
			OP_NEG:  neg_en = 1'b1;  // Always flip
			OP_ABS:  neg_en = sign;  // Only negatives
			OP_NABS: neg_en = ~sign; // Only zero and positives
			default: neg_en = 1'b0;  // OP_PASS
		endcase
	end

	neg_c #(
		.width(data_w),
		.speed(speed)
	) u_neg_c (
		.a  (in_req.operand),
		.neg(neg_en),
		.z  (negated)
	);

	// Negating word_min wraps back to word_min
	// NABS never negates a negative word, zero maps to zero
	always_comb begin
		mid_next.result = negated;
		mid_next.ovf    = neg_en & is_min & (in_req.op inside {OP_NEG, OP_ABS});
		mid_next.sat    = in_req.sat; // Acted on in the next stage
	end

	// Take a word when empty or when the current one leaves this cycle
	assign in_ready = ~out_valid | out_ready;

	// Valid bit
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid; // Refill or drain
		end
	end

	// Payload, loads only on a transfer so it holds while stalled
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_mid <= mid_next;
		end
	end

endmodule

//--- hdl/neg_c.sv
// Conditional two's complementer
module neg_c #(
	parameter int              width = 8,            // Operand width
	parameter lau_pkg::speed_e speed = lau_pkg::FAST // Prefix structure
) (
	input  logic [width-1:0] a,   // Operand
	input  logic             neg, // Negate enable
	output logic [width-1:0] z    // neg ? -a : a
);

	logic [width:0] ai; // Conditionally inverted operand, carry-in at bit 0
	logic [width:0] po; // Prefix propagate, po[i] = &ai[i:0]

	// -a = ~a + 1; carry-in of 1 sits below the inverted bits
	assign ai = {a ^ {width{neg}}, neg};

	// Carry into bit i is the AND of everything below it
	prefix_and #(
		.width(width + 1),
		.speed(speed)
	) u_prefix_and (
		.pi(ai),
		.po(po)
	);

	// Sum bit = inverted bit XOR incoming carry
	// neg low gives ai[0] = 0, so every carry is 0 and z = a
	assign z = ai[width:1] ^ po[width-1:0];

endmodule

//--- hdl/prefix_and.sv
// Parallel-prefix AND network
module prefix_and #(
	parameter int              width = 8,            // Number of propagate bits
	parameter lau_pkg::speed_e speed = lau_pkg::FAST // Tree structure
) (
	input  logic [width-1:0] pi, // Propagate in
	output logic [width-1:0] po  // po[i] = &pi[i:0]
);
	import lau_pkg::*;

	localparam int m = $clog2(width); // Levels of a full binary tree

	if (speed == FAST) begin : g_sklansky
		// Row l holds the prefixes of blocks of 2**l bits
		logic [width-1:0] pt [0:m];

		always_comb begin
			pt[0] = pi;
			for (int l = 1; l <= m; l++) begin
				for (int i = 0; i < width; i++) begin
					// Upper half of a 2**l block takes the lower half's top bit
					if (((i >> (l - 1)) & 1) == 1) begin
						pt[l][i] = pt[l-1][i] & pt[l-1][((i >> (l - 1)) << (l - 1)) - 1];
					end else begin
						pt[l][i] = pt[l-1][i]; // Lower half passes
					end
				end
			end
		end

		assign po = pt[m];
	end else if (speed == MEDIUM) begin : g_brent_kung
		// m up-sweep levels, then m-1 down-sweep levels
		localparam int lv = (m > 0) ? 2 * m - 1 : 0;

		logic [width-1:0] pt [0:lv];

		always_comb begin
			pt[0] = pi;

			// Up-sweep, combine at the top bit of each 2**l block
			for (int l = 1; l <= m; l++) begin
				for (int i = 0; i < width; i++) begin
					if ((i + 1) % (1 << l) == 0) begin
						pt[l][i] = pt[l-1][i] & pt[l-1][i - (1 << (l - 1))];
					end else begin
						pt[l][i] = pt[l-1][i];
					end
				end
			end

			// Down-sweep, fill in the middle of each block from the block below
			for (int l = m + 1; l <= lv; l++) begin
				for (int i = 0; i < width; i++) begin
					if (((i + 1) % (1 << (2 * m - l)) == (1 << (2 * m - l - 1))) &&
							(i >= (1 << (2 * m - l)))) begin
						pt[l][i] = pt[l-1][i] & pt[l-1][i - (1 << (2 * m - l - 1))];
					end else begin
						pt[l][i] = pt[l-1][i]; // Already complete or not yet due
					end
				end
			end
		end

		assign po = pt[lv];
	end else begin : g_serial
		// Plain ripple, width-1 AND gates deep
		logic [width-1:0] chain;

		assign chain[0] = pi[0];
		for (genvar i = 1; i < width; i++) begin : g_bit
			assign chain[i] = pi[i] & chain[i-1]; // Extend by one bit
		end

		assign po = chain;
	end

endmodule

//--- hdl/lau_pkg.sv
// Sign conditioning unit types
package lau_pkg;

	// Operand width, fixes the struct layouts below
	localparam int data_w = 16;

	// Signed two's-complement operand or result
	typedef logic [data_w-1:0] word_t;

	// Operation carried by each word
	typedef enum logic [1:0] {
		OP_PASS = 2'b00, // z = a
		OP_NEG  = 2'b01, // z = -a
		OP_ABS  = 2'b10, // z = |a|
		OP_NABS = 2'b11  // z = -|a|
	} op_e;

	// Prefix network structure
	typedef enum logic [1:0] {
		SLOW   = 2'b00, // Ripple chain, smallest
		MEDIUM = 2'b01, // Brent-Kung
		FAST   = 2'b10  // Sklansky, log2 depth
	} speed_e;

	// Request into the unit, 19 bits
	typedef struct packed {
		op_e   op;      // What to do with the operand
		logic  sat;     // Clamp to max positive on overflow
		word_t operand; // Signed input word
	} neg_req_t;

	// Record between negate and saturate stages, 18 bits
	typedef struct packed {
		word_t result; // Unclamped result
		logic  ovf;    // Most negative value was negated
		logic  sat;    // Saturation request, carried along
	} neg_mid_t;

	// Response out of the unit, 17 bits
	typedef struct packed {
		word_t result; // Final, possibly clamped, result
		logic  ovf;    // Overflow flag
	} neg_rsp_t;

	// Floor of log2(n); -1 when n < 1
	function automatic int log2floor(input int n);
		int    m;
		longint p; // Wide so doubling never wraps
		m = -1;
		p = 1;
		while (p <= n) begin
			m++;
			p = p * 2;
		end
		return m;
	endfunction

endpackage
